// ==== sources.f ====
+incdir+verilog
verilog/rv_ex_pkg.sv
verilog/ex_bus_if.sv
verilog/inst_decoder.sv
verilog/id_ex_buffer.sv
verilog/alu.sv
verilog/ex_stage.sv
verilog/rv_ex_top.sv
sim/tb_rv_ex.sv

// ==== Bender.yml ====
package:
  name: rv_ex

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_ex_pkg.sv
      - verilog/ex_bus_if.sv
      - verilog/inst_decoder.sv
      - verilog/id_ex_buffer.sv
      - verilog/alu.sv
      - verilog/ex_stage.sv
      - verilog/rv_ex_top.sv
  - target: simulation
    files:
      - sim/tb_rv_ex.sv

// ==== sim/tb_rv_ex.sv ====
// execute slice testbench
`timescale 1ns/100ps
`default_nettype none

module tb_rv_ex
    import rv_ex_pkg::*;
();

    typedef struct packed {
        logic [31:0] alu;
        logic        chk_alu;
        logic [4:0]  wb_addr;
        wr_sel_e     wr_sel;
        logic [31:0] pc_plus;
        logic [3:0]  we;
        logic [31:0] wdata;
        logic        csr_we;
        logic [31:0] csr_data;
    } exp_t;

    localparam logic [6:0] ALT = 7'h20;

    logic        clk_i;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic        inst_ready_o;
    logic        res_valid_o;
    logic        res_ready_i;
    logic [31:0] res_alu_o;
    logic [4:0]  res_wb_addr_o;
    wr_sel_e     res_wr_sel_o;
    logic [31:0] res_pc_plus_o;
    logic [3:0]  res_dmem_we_o;
    logic [31:0] res_mem_wdata_o;
    logic        res_csr_we_o;
    logic [31:0] res_csr_data_o;

    // stimulus table and expected results
    string       t_name[$];
    logic [31:0] t_inst[$];
    logic [31:0] t_pc[$];
    logic [31:0] t_rs1[$];
    logic [31:0] t_rs2[$];
    exp_t        t_exp[$];

    logic [4:0]  fwd_rd;
    logic [31:0] fwd_val;
    bit          table_ready = 1'b0;
    bit          test_bad;
    int          n_total;
    int          rx_idx = 0;
    int          n_ok = 0;
    int          n_bad = 0;
    int          err_count = 0;

    rv_ex_top uut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .inst_ready_o   (inst_ready_o),
        .res_valid_o    (res_valid_o),
        .res_ready_i    (res_ready_i),
        .res_alu_o      (res_alu_o),
        .res_wb_addr_o  (res_wb_addr_o),
        .res_wr_sel_o   (res_wr_sel_o),
        .res_pc_plus_o  (res_pc_plus_o),
        .res_dmem_we_o  (res_dmem_we_o),
        .res_mem_wdata_o(res_mem_wdata_o),
        .res_csr_we_o   (res_csr_we_o),
        .res_csr_data_o (res_csr_data_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // RV32I integer operation by funct3
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? x - y : x + y;
            3'd1: r = x << y[4:0];
            3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: r = (x < y) ? 32'd1 : 32'd0;
            3'd4: r = x ^ y;
            3'd5: begin
                if (alt) begin
                    r = $unsigned($signed(x) >>> y[4:0]);
                end else begin
                    r = x >> y[4:0];
                end
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    task automatic model(input logic [31:0] inst, input logic [31:0] pc,
                         input logic [31:0] rs1d, input logic [31:0] rs2d, output exp_t e);
        logic [2:0]  f3;
        logic [4:0]  rs1a;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] addr;
        f3    = inst[14:12];
        rs1a  = inst[19:15];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        // last writer overrides the register file data
        a = (fwd_rd != 5'd0 && fwd_rd == rs1a) ? fwd_val : rs1d;
        b = (fwd_rd != 5'd0 && fwd_rd == inst[24:20]) ? fwd_val : rs2d;
        e         = '0;
        e.wr_sel  = WR_NONE;
        e.wb_addr = inst[11:7];
        e.pc_plus = pc + 32'd4;
        e.chk_alu = 1'b1;
        case (inst[6:0])
            OPC_OP: begin
                e.wr_sel = WR_ALU;
                e.alu    = alu_ref(f3, inst[30], a, b);
            end
            OPC_OP_IMM: begin
                e.wr_sel = WR_ALU;
                e.alu    = alu_ref(f3, inst[30] && f3 == 3'd5, a, imm_i);
            end
            OPC_LUI: begin
                e.wr_sel = WR_ALU;
                e.alu    = {inst[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                e.wr_sel = WR_ALU;
                e.alu    = pc + {inst[31:12], 12'b0};
            end
            OPC_JAL: begin
                e.wr_sel = WR_PC4;
                e.alu    = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                e.wr_sel = WR_PC4;
                e.alu    = a + imm_i;
            end
            OPC_LOAD: begin
                e.wr_sel = WR_MEM;
                e.alu    = a + imm_i;
            end
            OPC_STORE: begin
                addr  = a + imm_s;
                e.alu = addr;
                case (f3)
                    3'd0: begin
                        case (addr[1:0])
                            2'd0: e.we = 4'b0001;
                            2'd1: e.we = 4'b0010;
                            2'd2: e.we = 4'b0100;
                            default: e.we = 4'b1000;
                        endcase
                        e.wdata = {4{b[7:0]}};
                    end
                    3'd1: begin
                        e.we    = (addr[1:0] < 2'd2) ? 4'b0011 : 4'b1100;
                        e.wdata = {2{b[15:0]}};
                    end
                    default: begin
                        e.we    = 4'b1111;
                        e.wdata = b;
                    end
                endcase
            end
            OPC_SYSTEM: begin
                e.chk_alu  = 1'b0;
                e.csr_we   = (f3 == 3'd1) || (f3 == 3'd5);
                e.csr_data = (f3 == 3'd5) ? {27'd0, rs1a} : a;
            end
            default: begin
                e.chk_alu = 1'b0;
            end
        endcase
        if ((e.wr_sel == WR_ALU || e.wr_sel == WR_PC4) && e.wb_addr != 5'd0) begin
            fwd_rd  = e.wb_addr;
            fwd_val = (e.wr_sel == WR_PC4) ? e.pc_plus : e.alu;
        end
    endtask

    task automatic add_test(input string name, input logic [31:0] inst,
                            input logic [31:0] rs1d, input logic [31:0] rs2d);
        exp_t        e;
        logic [31:0] pc;
        pc = 32'h0000_1000 + 32'(t_inst.size()) * 32'd4;
        model(inst, pc, rs1d, rs2d, e);
        t_name.push_back(name);
        t_inst.push_back(inst);
        t_pc.push_back(pc);
        t_rs1.push_back(rs1d);
        t_rs2.push_back(rs2d);
        t_exp.push_back(e);
    endtask

    task automatic build_table();
        fwd_rd  = 5'd0;
        fwd_val = 32'd0;
        add_test("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 32'd100, 32'd23);
        add_test("sub", enc_r(ALT, 5'd2, 5'd1, 3'd0, 5'd4), 32'd5, 32'd9);
        add_test("sll", enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd5), 32'h8000_00f1, 32'h24);
        add_test("slt", enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd6), 32'hffff_fff0, 32'd3);
        add_test("sltu", enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd7), 32'hffff_fff0, 32'd3);
        add_test("xor", enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd8), 32'hf0f0_1234, 32'h0ff0_ffff);
        add_test("srl", enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd9), 32'h8000_0000, 32'd31);
        add_test("sra", enc_r(ALT, 5'd2, 5'd1, 3'd5, 5'd10), 32'h8000_0000, 32'd4);
        add_test("or", enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd11), 32'h00ff_0000, 32'h0000_0f0f);
        add_test("and", enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd12), 32'hff00_ff00, 32'h0ff0_0ff0);
        add_test("addi", enc_i(12'hff6, 5'd1, 3'd0, 5'd13, OPC_OP_IMM), 32'd20, 32'd0);
        add_test("slti", enc_i(12'h800, 5'd1, 3'd2, 5'd14, OPC_OP_IMM), 32'hffff_f000, 32'd0);
        add_test("sltiu", enc_i(12'hfff, 5'd1, 3'd3, 5'd15, OPC_OP_IMM), 32'd7, 32'd0);
        add_test("xori", enc_i(12'h0f0, 5'd1, 3'd4, 5'd16, OPC_OP_IMM), 32'h1234_5678, 32'd0);
        add_test("ori", enc_i(12'h00f, 5'd1, 3'd6, 5'd17, OPC_OP_IMM), 32'h1234_5670, 32'd0);
        add_test("andi", enc_i(12'h0ff, 5'd1, 3'd7, 5'd18, OPC_OP_IMM), 32'h1234_5678, 32'd0);
        add_test("slli", enc_i(12'h005, 5'd1, 3'd1, 5'd19, OPC_OP_IMM), 32'h0000_0103, 32'd0);
        add_test("srli", enc_i(12'h008, 5'd1, 3'd5, 5'd20, OPC_OP_IMM), 32'hf000_0000, 32'd0);
        add_test("srai", enc_i(12'h408, 5'd1, 3'd5, 5'd21, OPC_OP_IMM), 32'hf000_0000, 32'd0);
        add_test("lui", enc_u(20'habcde, 5'd22, OPC_LUI), 32'd0, 32'd0);
        add_test("auipc", enc_u(20'h00010, 5'd23, OPC_AUIPC), 32'd0, 32'd0);
        // forwarding chain with stale register data supplied
        add_test("fwd_src", enc_i(12'h005, 5'd1, 3'd0, 5'd24, OPC_OP_IMM), 32'd10, 32'd0);
        add_test("fwd_rs1", enc_r(7'h00, 5'd2, 5'd24, 3'd0, 5'd25), 32'hdead_beef, 32'd1);
        add_test("fwd_rs2", enc_r(ALT, 5'd25, 5'd1, 3'd0, 5'd26), 32'd100, 32'h5555);
        // x26 still forwards past the x0 write
        add_test("x0_write", enc_i(12'h07f, 5'd1, 3'd0, 5'd0, OPC_OP_IMM), 32'd1, 32'd0);
        add_test("x0_read", enc_r(7'h00, 5'd26, 5'd0, 3'd0, 5'd27), 32'd0, 32'd9);
        // stores at every offset
        add_test("sb_off0", enc_s(12'h000, 5'd2, 5'd1, 3'd0), 32'h100, 32'h1122_33a5);
        add_test("sb_off1", enc_s(12'h001, 5'd2, 5'd1, 3'd0), 32'h100, 32'h1122_33a6);
        add_test("sb_off2", enc_s(12'h002, 5'd2, 5'd1, 3'd0), 32'h100, 32'h1122_33a7);
        add_test("sb_off3", enc_s(12'h003, 5'd2, 5'd1, 3'd0), 32'h100, 32'h1122_33a8);
        add_test("sh_off0", enc_s(12'h000, 5'd2, 5'd1, 3'd1), 32'h200, 32'h1234_5678);
        add_test("sh_off2", enc_s(12'h002, 5'd2, 5'd1, 3'd1), 32'h200, 32'h8765_4321);
        add_test("sw", enc_s(12'h008, 5'd2, 5'd1, 3'd2), 32'h300, 32'hcafe_f00d);
        add_test("sw_fwd", enc_s(12'hffc, 5'd27, 5'd1, 3'd2), 32'h300, 32'h0bad_0bad);
        add_test("lw_addr", enc_i(12'h00c, 5'd9, 3'd2, 5'd8, OPC_LOAD), 32'h400, 32'd0);
        // jumps and link forwarding
        add_test("jal", enc_j(21'h000040, 5'd1), 32'd0, 32'd0);
        add_test("jalr", enc_i(12'h008, 5'd5, 3'd0, 5'd1, OPC_JALR), 32'h2000, 32'd0);
        add_test("fwd_link", enc_i(12'h000, 5'd1, 3'd0, 5'd28, OPC_OP_IMM), 32'd3, 32'd0);
        add_test("csrrw", enc_i(12'h300, 5'd6, 3'd1, 5'd0, OPC_SYSTEM), 32'h1234_abcd, 32'd0);
        add_test("csrrwi", enc_i(12'h305, 5'h15, 3'd5, 5'd0, OPC_SYSTEM), 32'hffff_ffff, 32'd0);
        add_test("branch", {7'h00, 5'd2, 5'd1, 3'd0, 5'h08, 7'b1100011}, 32'd1, 32'd2);
        add_test("fence", 32'h0000_000f, 32'd0, 32'd0);
        n_total = t_inst.size();
    endtask

    task automatic check_word(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, sig, got, exp);
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_mask(input string sig, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%b exp=%b", $time, sig, got, exp);
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_sel(input string sig, input wr_sel_e got, input wr_sel_e exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%s exp=%s", $time, sig, got.name(), exp.name());
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%b exp=%b", $time, sig, got, exp);
            err_count++;
            test_bad = 1'b1;
        end
    endtask

    task automatic report_test(input string name);
        if (test_bad) begin
            n_bad++;
        end else begin
            n_ok++;
        end
        $display("test %0d %s: %s", n_ok + n_bad, name, test_bad ? "bad" : "ok");
    endtask

    task automatic check_result();
        exp_t e;
        if (rx_idx >= n_total) begin
            $display("extra result at %0t with no instruction left to match it", $time);
            err_count++;
        end else begin
            e        = t_exp[rx_idx];
            test_bad = 1'b0;
            check_sel("res_wr_sel_o", res_wr_sel_o, e.wr_sel);
            check_mask("res_dmem_we_o", res_dmem_we_o, e.we);
            check_bit("res_csr_we_o", res_csr_we_o, e.csr_we);
            if (e.chk_alu) begin
                check_word("res_alu_o", res_alu_o, e.alu);
            end
            if (e.wr_sel != WR_NONE) begin
                check_word("res_wb_addr_o", 32'(res_wb_addr_o), 32'(e.wb_addr));
            end
            if (e.wr_sel == WR_PC4) begin
                check_word("res_pc_plus_o", res_pc_plus_o, e.pc_plus);
            end
            if (e.we != 4'b0000) begin
                check_word("res_mem_wdata_o", res_mem_wdata_o, e.wdata);
            end
            if (e.csr_we) begin
                check_word("res_csr_data_o", res_csr_data_o, e.csr_data);
            end
            report_test(t_name[rx_idx]);
            rx_idx++;
        end
    endtask

    // random back-pressure on the result port
    initial begin
        res_ready_i = 1'b0;
        void'($urandom(56));
        forever begin
            @(posedge clk_i);
            res_ready_i <= ($urandom % 3) != 0;
        end
    end

    // a transfer happens at the next rising edge
    initial begin
        forever begin
            @(negedge clk_i);
            if (rst_n_i && res_valid_o && res_ready_i) begin
                check_result();
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (n_total * 20) @(posedge clk_i);
        $display("timeout: %0d of %0d results arrived", rx_idx, n_total);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = 32'd0;
        pc_i         = 32'd0;
        rs1_data_i   = 32'd0;
        rs2_data_i   = 32'd0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        test_bad = 1'b0;
        check_bit("res_valid_o", res_valid_o, 1'b0);
        check_mask("res_dmem_we_o", res_dmem_we_o, 4'b0000);
        check_bit("res_csr_we_o", res_csr_we_o, 1'b0);
        check_bit("inst_ready_o", inst_ready_o, 1'b1);
        report_test("reset");
        for (int i = 0; i < n_total; i++) begin
            @(posedge clk_i);
            inst_valid_i <= 1'b1;
            inst_i       <= t_inst[i];
            pc_i         <= t_pc[i];
            rs1_data_i   <= t_rs1[i];
            rs2_data_i   <= t_rs2[i];
            @(negedge clk_i);
            while (!inst_ready_o) begin
                @(negedge clk_i);
            end
        end
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        while (rx_idx < n_total) begin
            @(posedge clk_i);
        end
        // extra results would still show up here
        repeat (10) @(posedge clk_i);
        $display("%0d tests, %0d ok, %0d bad, %0d check errors",
                 n_ok + n_bad, n_ok, n_bad, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_ex_top.sv ====
// RV32I execute slice top
`timescale 1ns/100ps
`default_nettype none

`include "rv_ex_consts.svh"

module rv_ex_top
    import rv_ex_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  inst_valid_i,
    input  logic [31:0]           inst_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  logic [`RV_XLEN-1:0]   rs1_data_i,
    input  logic [`RV_XLEN-1:0]   rs2_data_i,
    output logic                  inst_ready_o,
    output logic                  res_valid_o,
    input  logic                  res_ready_i,
    output logic [`RV_XLEN-1:0]   res_alu_o,
    output logic [`RV_REG_AW-1:0] res_wb_addr_o,
    output wr_sel_e               res_wr_sel_o,
    output logic [`RV_XLEN-1:0]   res_pc_plus_o,
    output logic [3:0]            res_dmem_we_o,
    output logic [`RV_XLEN-1:0]   res_mem_wdata_o,
    output logic                  res_csr_we_o,
    output logic [`RV_XLEN-1:0]   res_csr_data_o
);

    ex_bus_if dec_to_buf ();
    ex_bus_if buf_to_ex ();

    inst_decoder u_decoder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .inst_ready_o(inst_ready_o),
        .out_bus     (dec_to_buf.src)
    );

    id_ex_buffer u_buffer (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .in_bus (dec_to_buf.dst),
        .out_bus(buf_to_ex.src)
    );

    ex_stage u_ex (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .in_bus         (buf_to_ex.dst),
        .res_valid_o    (res_valid_o),
        .res_ready_i    (res_ready_i),
        .res_alu_o      (res_alu_o),
        .res_wb_addr_o  (res_wb_addr_o),
        .res_wr_sel_o   (res_wr_sel_o),
        .res_pc_plus_o  (res_pc_plus_o),
        .res_dmem_we_o  (res_dmem_we_o),
        .res_mem_wdata_o(res_mem_wdata_o),
        .res_csr_we_o   (res_csr_we_o),
        .res_csr_data_o (res_csr_data_o)
    );

endmodule

`default_nettype wire

// ==== verilog/ex_stage.sv ====
// execute stage
`timescale 1ns/100ps
`default_nettype none

`include "rv_ex_consts.svh"

module ex_stage
    import rv_ex_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    ex_bus_if.dst                 in_bus,
    output logic                  res_valid_o,
    input  logic                  res_ready_i,
    output logic [`RV_XLEN-1:0]   res_alu_o,
    output logic [`RV_REG_AW-1:0] res_wb_addr_o,
    output wr_sel_e               res_wr_sel_o,
    output logic [`RV_XLEN-1:0]   res_pc_plus_o,
    output logic [3:0]            res_dmem_we_o,
    output logic [`RV_XLEN-1:0]   res_mem_wdata_o,
    output logic                  res_csr_we_o,
    output logic [`RV_XLEN-1:0]   res_csr_data_o
);

    ex_bundle_t            cur;
    logic                  accept;
    logic [`RV_REG_AW-1:0] fwd_rd;
    logic [`RV_XLEN-1:0]   fwd_data;
    logic [`RV_XLEN-1:0]   rs1_val;
    logic [`RV_XLEN-1:0]   rs2_val;
    logic [`RV_XLEN-1:0]   op_a;
    logic [`RV_XLEN-1:0]   op_b;
    logic [`RV_XLEN-1:0]   alu_res;
    logic [`RV_XLEN-1:0]   wb_val;
    logic [`RV_XLEN-1:0]   st_data;
    logic [`RV_XLEN-1:0]   csr_data;
    logic [3:0]            byte_we;

    assign cur          = in_bus.bundle;
    assign in_bus.ready = !res_valid_o || res_ready_i;
    assign accept       = in_bus.valid && in_bus.ready;

    // x0 never forwards
    assign rs1_val = (fwd_rd != '0 && fwd_rd == cur.rs1_addr) ? fwd_data : cur.rs1_data;
    assign rs2_val = (fwd_rd != '0 && fwd_rd == cur.rs2_addr) ? fwd_data : cur.rs2_data;

    assign op_a = (cur.opa_sel == PC) ? cur.pc : rs1_val;
    assign op_b = (cur.opb_sel == IMM) ? cur.imm : rs2_val;

    alu u_alu (
        .op_a_i  (op_a),
        .op_b_i  (op_b),
        .alu_op_i(cur.alu_op),
        .result_o(alu_res)
    );

    assign wb_val = (cur.wr_sel == WR_PC4) ? cur.pc_plus : alu_res;

    // byte lanes from size and address offset
    always_comb begin
        byte_we = 4'b0000;
        st_data = rs2_val;
        case (cur.funct3[1:0])
            2'b00: begin
                byte_we = 4'b0001 << alu_res[1:0];
                st_data = {4{rs2_val[7:0]}};
            end
            2'b01: begin
                byte_we = alu_res[1] ? 4'b1100 : 4'b0011;
                st_data = {2{rs2_val[15:0]}};
            end
            2'b10: begin
                byte_we = 4'b1111;
            end
            default: begin
                byte_we = 4'b0000;
            end
        endcase
        if (!cur.is_store) begin
            byte_we = 4'b0000;
        end
    end

    // csrrwi takes the rs1 field as a zero-extended immediate
    assign csr_data = (cur.funct3 == 3'b001) ? rs1_val :
                      (cur.funct3 == 3'b101) ? {{(`RV_XLEN-`RV_REG_AW){1'b0}}, cur.rs1_addr} :
                      '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fwd_rd   <= '0;
            fwd_data <= '0;
        end else if (accept && (cur.wr_sel == WR_ALU || cur.wr_sel == WR_PC4)
                     && cur.rd_addr != '0) begin
            fwd_rd   <= cur.rd_addr;
            fwd_data <= wb_val;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            res_valid_o   <= 1'b0;
            res_dmem_we_o <= 4'b0000;
            res_csr_we_o  <= 1'b0;
        end else if (accept) begin
            res_valid_o   <= 1'b1;
            res_dmem_we_o <= byte_we;
            res_csr_we_o  <= cur.csr_we;
        end else if (res_ready_i) begin
            res_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_alu_o       <= alu_res;
            res_wb_addr_o   <= cur.rd_addr;
            res_wr_sel_o    <= cur.wr_sel;
            res_pc_plus_o   <= cur.pc_plus;
            res_mem_wdata_o <= st_data;
            res_csr_data_o  <= csr_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
// RV32I arithmetic and logic unit
`timescale 1ns/100ps
`default_nettype none

`include "rv_ex_consts.svh"

module alu
    import rv_ex_pkg::*;
(
    input  logic [`RV_XLEN-1:0] op_a_i,
    input  logic [`RV_XLEN-1:0] op_b_i,
    input  alu_op_e             alu_op_i,
    output logic [`RV_XLEN-1:0] result_o
);

    logic [4:0] shamt;

    assign shamt = op_b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ADD: begin
                result_o = op_a_i + op_b_i;
            end
            SUB: begin
                result_o = op_a_i - op_b_i;
            end
            SLL: begin
                result_o = op_a_i << shamt;
            end
            SLT: begin
                result_o = {{(`RV_XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
            end
            SLTU: begin
                result_o = {{(`RV_XLEN-1){1'b0}}, op_a_i < op_b_i};
            end
            XOR: begin
                result_o = op_a_i ^ op_b_i;
            end
            SRL: begin
                result_o = op_a_i >> shamt;
            end
            SRA: begin
                // arithmetic shift keeps the sign
                result_o = $unsigned($signed(op_a_i) >>> shamt);
            end
            OR: begin
                result_o = op_a_i | op_b_i;
            end
            AND: begin
                result_o = op_a_i & op_b_i;
            end
            PASS_B: begin
                result_o = op_b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/id_ex_buffer.sv ====
// decode to execute pipeline buffer
`timescale 1ns/100ps
`default_nettype none

`include "rv_ex_consts.svh"

module id_ex_buffer
    import rv_ex_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    ex_bus_if.dst in_bus,
    ex_bus_if.src out_bus
);

    localparam int PW = (`RV_BUF_DEPTH > 1) ? $clog2(`RV_BUF_DEPTH) : 1;
    localparam int CW = $clog2(`RV_BUF_DEPTH + 1);

    ex_bundle_t    mem [`RV_BUF_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    assign in_bus.ready  = (count != CW'(`RV_BUF_DEPTH));
    assign out_bus.valid = (count != '0);
    assign out_bus.bundle = mem[rd_ptr];

    assign do_wr = in_bus.valid && in_bus.ready;
    assign do_rd = out_bus.valid && out_bus.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PW'(`RV_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PW'(`RV_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_bus.bundle;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
// RV32I instruction decoder
`timescale 1ns/100ps
`default_nettype none

`include "rv_ex_consts.svh"

module inst_decoder
    import rv_ex_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  logic [31:0]         inst_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] rs1_data_i,
    input  logic [`RV_XLEN-1:0] rs2_data_i,
    output logic                inst_ready_o,
    ex_bus_if.src               out_bus
);

    logic                out_valid;
    ex_bundle_t          out_bundle;
    ex_bundle_t          dec;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // funct3 plus the alternate bit picks the operation
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign funct3 = inst_i[14:12];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        dec          = '0;
        dec.pc       = pc_i;
        dec.pc_plus  = pc_i + `RV_XLEN'd4;
        dec.rs1_data = rs1_data_i;
        dec.rs2_data = rs2_data_i;
        dec.rs1_addr = inst_i[19:15];
        dec.rs2_addr = inst_i[24:20];
        dec.rd_addr  = inst_i[11:7];
        dec.funct3   = funct3;
        dec.alu_op   = ADD;
        dec.opa_sel  = RS1;
        dec.opb_sel  = IMM;
        dec.wr_sel   = WR_NONE;
        case (opcode_e'(inst_i[6:0]))
            OPC_OP: begin
                dec.alu_op  = alu_from_funct3(funct3, inst_i[30]);
                dec.opb_sel = RS2;
                dec.wr_sel  = WR_ALU;
            end
            OPC_OP_IMM: begin
                // only srai uses bit 30
                dec.imm    = imm_i;
                dec.alu_op = alu_from_funct3(funct3, inst_i[30] && funct3 == 3'b101);
                dec.wr_sel = WR_ALU;
            end
            OPC_LUI: begin
                dec.imm    = imm_u;
                dec.alu_op = PASS_B;
                dec.wr_sel = WR_ALU;
            end
            OPC_AUIPC: begin
                dec.imm     = imm_u;
                dec.opa_sel = PC;
                dec.wr_sel  = WR_ALU;
            end
            OPC_JAL: begin
                dec.imm     = imm_j;
                dec.opa_sel = PC;
                dec.wr_sel  = WR_PC4;
            end
            OPC_JALR: begin
                dec.imm    = imm_i;
                dec.wr_sel = WR_PC4;
            end
            OPC_LOAD: begin
                dec.imm    = imm_i;
                dec.wr_sel = WR_MEM;
            end
            OPC_STORE: begin
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
            end
            OPC_SYSTEM: begin
                // csrrw and csrrwi only
                dec.csr_we = (funct3 == 3'b001) || (funct3 == 3'b101);
            end
            default: begin
                dec.wr_sel = WR_NONE;
            end
        endcase
    end

    // stall while the held bundle is not taken
    assign inst_ready_o = !out_valid || out_bus.ready;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid <= 1'b0;
        end else if (inst_valid_i && inst_ready_o) begin
            out_valid <= 1'b1;
        end else if (out_bus.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_valid_i && inst_ready_o) begin
            out_bundle <= dec;
        end
    end

    assign out_bus.valid  = out_valid;
    assign out_bus.bundle = out_bundle;

endmodule

`default_nettype wire

// ==== verilog/ex_bus_if.sv ====
// stage to stage bundle bus
`timescale 1ns/100ps
`default_nettype none

interface ex_bus_if
    import rv_ex_pkg::*;
();

    logic       valid;
    logic       ready;
    ex_bundle_t bundle;

    // upstream side
    modport src (
        output valid,
        output bundle,
        input  ready
    );

    // downstream side
    modport dst (
        input  valid,
        input  bundle,
        output ready
    );

endinterface

`default_nettype wire

// ==== verilog/rv_ex_pkg.sv ====
// execute slice types
`default_nettype none

`include "rv_ex_consts.svh"

package rv_ex_pkg;

    // major opcodes handled by the slice
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    typedef enum logic {
        RS1,
        PC
    } opa_sel_e;

    typedef enum logic {
        RS2,
        IMM
    } opb_sel_e;

    typedef enum logic [1:0] {
        WR_NONE,
        WR_ALU,
        WR_MEM,
        WR_PC4
    } wr_sel_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   pc_plus;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_REG_AW-1:0] rs1_addr;
        logic [`RV_REG_AW-1:0] rs2_addr;
        logic [`RV_REG_AW-1:0] rd_addr;
        logic [2:0]            funct3;
        alu_op_e               alu_op;
        opa_sel_e              opa_sel;
        opb_sel_e              opb_sel;
        wr_sel_e               wr_sel;
        logic                  is_store;
        logic                  csr_we;
    } ex_bundle_t;

endpackage

`default_nettype wire

// ==== verilog/rv_ex_consts.svh ====
// execute slice constants
`ifndef RV_EX_CONSTS_SVH
`define RV_EX_CONSTS_SVH

// data path width
`define RV_XLEN 32

// register file address width
`define RV_REG_AW 5

// entries in the decode to execute buffer
`define RV_BUF_DEPTH 2

`endif
